//--- hw/sch_pkg.sv
// four banks fixed; bank state and command encodings must match the bank controllers
package sch_pkg;

  //////////////////////////////
  // widths and constants

  localparam int num_banks = 4;

  typedef logic [1:0]  bank_idx_t;
  typedef logic [13:0] row_addr_t;
  typedef logic [7:0]  age_t;
  typedef logic [2:0]  run_cnt_t;
  typedef logic [20:0] sch_word_t;   // {cmd, addr, 1'b0, bank}

  localparam age_t age_max       = 8'd255;
  localparam int   run_wrap      = 4;   // run counters go 4 -> 1
  localparam int   act_run_limit = 3;

  //////////////////////////////
  // encodings

  typedef enum logic [3:0] {
    b_idle        = 4'd0,
    b_act_check   = 4'd1,
    b_active      = 4'd2,
    b_act_standby = 4'd3,
    b_write_check = 4'd4,
    b_write       = 4'd5,
    b_read_check  = 4'd6,
    b_read        = 4'd7,
    b_pre_check   = 4'd8,
    b_pre         = 4'd9
  } bank_state_t;

  typedef enum logic [3:0] {
    cmd_nop       = 4'd0,
    cmd_active    = 4'd1,
    cmd_read      = 4'd2,
    cmd_write     = 4'd3,
    cmd_precharge = 4'd4
  } cmd_t;

  typedef enum logic [2:0] {
    cls_none  = 3'd0,
    cls_act   = 3'd1,
    cls_write = 3'd2,
    cls_read  = 3'd3,
    cls_pre   = 3'd4
  } sch_class_t;

  // check state or issue state of the class
  function automatic logic in_class(bank_state_t st, sch_class_t cls);
    case (cls)
      cls_act:   return st inside {b_act_check, b_active};
      cls_write: return st inside {b_write_check, b_write};
      cls_read:  return st inside {b_read_check, b_read};
      cls_pre:   return st inside {b_pre_check, b_pre};
      default:   return 1'b0;
    endcase
  endfunction

endpackage

//--- hw/bank_age_tracker.sv
// ages saturate at age_max; idle and act standby restart the count at the next edge
`timescale 1ns/1ps

module bank_age_tracker (
  input  logic                 clk,
  input  logic                 rst_n,
  input  sch_pkg::bank_state_t ba_state [sch_pkg::num_banks],
  output sch_pkg::age_t        bank_age [sch_pkg::num_banks]
);

  import sch_pkg::*;

  //////////////////////////////
  // one counter per bank

  for (genvar i = 0; i < num_banks; i++) begin : g_age
    logic restart;

    assign restart = (ba_state[i] == b_idle) || (ba_state[i] == b_act_standby);

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        bank_age[i] <= '0;
      end else if (restart) begin
        bank_age[i] <= '0;
      end else if (bank_age[i] != age_max) begin
        bank_age[i] <= bank_age[i] + 1'b1;  // hold at max
      end
    end

    // only a restart may bring the age down
    a_age_mono: assert property (@(posedge clk) disable iff (!rst_n)
      (bank_age[i] < $past(bank_age[i])) |-> (bank_age[i] == '0))
      else $error("bank %0d age fell from %0d to %0d", i, $past(bank_age[i]), bank_age[i]);
  end

endmodule

//--- hw/class_arbiter.sv
// run counters wrap 4 -> 1; the grant is purely combinational from states and registered counters
`timescale 1ns/1ps

module class_arbiter (
  input  logic                  clk,
  input  logic                  rst_n,
  input  sch_pkg::bank_state_t  ba_state [sch_pkg::num_banks],
  input  sch_pkg::bank_idx_t    oldest_bank,
  output sch_pkg::sch_class_t   grant_class
);

  import sch_pkg::*;

  run_cnt_t   act_run;
  run_cnt_t   write_run;
  run_cnt_t   read_run;
  logic       any_active;
  logic       any_write;
  logic       any_read;
  logic       act_pend;
  logic       write_pend;
  logic       read_pend;
  logic       pre_pend;
  logic       any_busy;
  sch_class_t access_class;

  function automatic run_cnt_t run_inc(run_cnt_t cnt);
    return (cnt == run_cnt_t'(run_wrap)) ? run_cnt_t'(1) : run_cnt_t'(cnt + 1'b1);
  endfunction

  //////////////////////////////
  // per-class flags

  always_comb begin
    any_active = 1'b0;
    any_write  = 1'b0;
    any_read   = 1'b0;
    act_pend   = 1'b0;
    write_pend = 1'b0;
    read_pend  = 1'b0;
    pre_pend   = 1'b0;
    any_busy   = 1'b0;
    for (int i = 0; i < num_banks; i++) begin
      any_active |= (ba_state[i] == b_active);
      any_write  |= (ba_state[i] == b_write);
      any_read   |= (ba_state[i] == b_read);
      act_pend   |= in_class(ba_state[i], cls_act);
      write_pend |= in_class(ba_state[i], cls_write);
      read_pend  |= in_class(ba_state[i], cls_read);
      pre_pend   |= in_class(ba_state[i], cls_pre);
      any_busy   |= !(ba_state[i] inside {b_idle, b_act_standby});
    end
  end

  //////////////////////////////
  // run counters

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      act_run   <= '0;
      write_run <= '0;
      read_run  <= '0;
    end else begin
      if (any_active) act_run <= run_inc(act_run);
      if (any_write)
        write_run <= run_inc(write_run);
      else if (any_read)
        write_run <= '0;  // read took over
      if (any_read)
        read_run <= run_inc(read_run);
      else if (any_write)
        read_run <= '0;
    end
  end

  //////////////////////////////
  // class decision

  always_comb begin
    access_class = cls_none;
    if (write_pend && read_pend) begin
      if (write_run != '0 && read_run == '0)
        access_class = cls_write;   // write streak
      else if (read_run != '0 && write_run == '0)
        access_class = cls_read;    // read streak
      else if (in_class(ba_state[oldest_bank], cls_write))
        access_class = cls_write;
      else
        access_class = cls_read;
    end else if (write_pend) begin
      access_class = cls_write;
    end else if (read_pend) begin
      access_class = cls_read;
    end
  end

  always_comb begin
    if (!(act_pend || write_pend || read_pend || pre_pend))
      grant_class = cls_none;
    else if (pre_pend)
      grant_class = cls_pre;
    else if (act_pend && (access_class == cls_none ||
                          in_class(ba_state[oldest_bank], cls_act) ||
                          act_run < run_cnt_t'(act_run_limit)))
      grant_class = cls_act;
    else
      grant_class = access_class;
  end

  // nothing granted only when every bank rests in idle or standby
  a_none_iff_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    (grant_class == cls_none) == !any_busy)
    else $error("grant_class %s with bank activity %b", grant_class.name(), any_busy);

endmodule

//--- hw/oldest_bank_select.sv
// ties resolve to the lowest bank index; a full issue FIFO stalls every bank
`timescale 1ns/1ps

module oldest_bank_select (
  input  sch_pkg::bank_state_t          ba_state [sch_pkg::num_banks],
  input  sch_pkg::age_t                 bank_age [sch_pkg::num_banks],
  input  sch_pkg::sch_class_t           grant_class,
  input  logic                          isu_fifo_full,
  output sch_pkg::bank_idx_t            oldest_bank,
  output logic [sch_pkg::num_banks-1:0] ba_stall
);

  import sch_pkg::*;

  age_t      best_age;
  age_t      cls_age;
  bank_idx_t cls_bank;
  logic      cls_hit;
  logic      older_peer;

  //////////////////////////////
  // oldest overall

  always_comb begin
    oldest_bank = '0;
    best_age    = bank_age[0];
    for (int i = 1; i < num_banks; i++) begin
      if (bank_age[i] > best_age) begin  // strict, lower index wins ties
        best_age    = bank_age[i];
        oldest_bank = bank_idx_t'(i);
      end
    end
  end

  //////////////////////////////
  // oldest in granted class

  always_comb begin
    cls_hit  = 1'b0;
    cls_bank = '0;
    cls_age  = '0;
    for (int i = 0; i < num_banks; i++) begin
      if (in_class(ba_state[i], grant_class) && (!cls_hit || bank_age[i] > cls_age)) begin
        cls_hit  = 1'b1;
        cls_bank = bank_idx_t'(i);
        cls_age  = bank_age[i];
      end
    end
  end

  always_comb begin
    ba_stall = '1;
    if (grant_class != cls_none && !isu_fifo_full && cls_hit)
      ba_stall[cls_bank] = 1'b0;
  end

  // a released bank sits in the granted class with no older bank beside it
  always_comb begin
    older_peer = 1'b0;
    for (int i = 0; i < num_banks; i++)
      older_peer |= in_class(ba_state[i], grant_class) && (bank_age[i] > bank_age[cls_bank]);
    a_one_release: assert final ($onehot0(~ba_stall) &&
      (&ba_stall || (in_class(ba_state[cls_bank], grant_class) && !older_peer)))
      else $error("bad stall vector %b for class %s", ba_stall, grant_class.name());
  end

endmodule

//--- hw/cmd_issue_mux.sv
// lowest issuing bank wins; no issuing bank gives a NOP word carrying bank 0 address
`timescale 1ns/1ps

module cmd_issue_mux (
  input  sch_pkg::bank_state_t ba_state [sch_pkg::num_banks],
  input  sch_pkg::row_addr_t   ba_addr  [sch_pkg::num_banks],
  output sch_pkg::sch_word_t   sch_out,
  output logic                 sch_issue
);

  import sch_pkg::*;

  bank_idx_t sel;
  cmd_t      sel_cmd;

  function automatic cmd_t state_cmd(bank_state_t st);
    case (st)
      b_active: return cmd_active;
      b_read:   return cmd_read;
      b_write:  return cmd_write;
      b_pre:    return cmd_precharge;
      default:  return cmd_nop;
    endcase
  endfunction

  //////////////////////////////
  // first bank in an issue state

  always_comb begin
    sch_issue = 1'b0;
    sel       = '0;
    for (int i = 0; i < num_banks; i++) begin
      if (!sch_issue && state_cmd(ba_state[i]) != cmd_nop) begin
        sch_issue = 1'b1;
        sel       = bank_idx_t'(i);
      end
    end
  end

  // sel stays 0 with nothing issuing and maps to nop
  assign sel_cmd = state_cmd(ba_state[sel]);

  assign sch_out = {sel_cmd, ba_addr[sel], 1'b0, sel};  // bank field msb unused

endmodule

//--- hw/cmd_scheduler.sv
// four banks; all outputs combinational from bank inputs, plain levels with no handshake
`timescale 1ns/1ps

module cmd_scheduler (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   isu_fifo_full,
  input  sch_pkg::bank_state_t                   ba_state [sch_pkg::num_banks],
  input  sch_pkg::row_addr_t                     ba_addr  [sch_pkg::num_banks],
  output logic [sch_pkg::num_banks-1:0]          ba_stall,
  output sch_pkg::sch_word_t                     sch_out,
  output logic                                   sch_issue
);

  import sch_pkg::*;

  age_t       bank_age [num_banks];
  bank_idx_t  oldest_bank;
  sch_class_t grant_class;

  //////////////////////////////
  // age and arbitration

  bank_age_tracker i_bank_age_tracker (
    .clk      (clk),
    .rst_n    (rst_n),
    .ba_state (ba_state),
    .bank_age (bank_age)
  );

  class_arbiter i_class_arbiter (
    .clk         (clk),
    .rst_n       (rst_n),
    .ba_state    (ba_state),
    .oldest_bank (oldest_bank),
    .grant_class (grant_class)
  );

  oldest_bank_select i_oldest_bank_select (
    .ba_state      (ba_state),
    .bank_age      (bank_age),
    .grant_class   (grant_class),
    .isu_fifo_full (isu_fifo_full),
    .oldest_bank   (oldest_bank),
    .ba_stall      (ba_stall)
  );

  //////////////////////////////
  // issue path

  cmd_issue_mux i_cmd_issue_mux (
    .ba_state  (ba_state),
    .ba_addr   (ba_addr),
    .sch_out   (sch_out),
    .sch_issue (sch_issue)
  );

endmodule

//--- tb/sch_checker.sv
// model updates on the rising edge; outputs compared on the falling edge while not in reset
`timescale 1ns/1ps

module sch_checker (
  input  logic                          clk,
  input  logic                          rst_n,
  input  int                            phase,
  input  logic                          isu_fifo_full,
  input  sch_pkg::bank_state_t          ba_state [sch_pkg::num_banks],
  input  sch_pkg::row_addr_t            ba_addr  [sch_pkg::num_banks],
  input  logic [sch_pkg::num_banks-1:0] ba_stall,
  input  sch_pkg::sch_word_t            sch_out,
  input  logic                          sch_issue,
  output logic                          finished,
  output int                            error_count
);

  import sch_pkg::*;

  string test_name [1:6] = '{"issue_word", "oldest_grant", "fifo_full",
                             "rw_streak", "act_vs_access", "pre_first"};
  int age [num_banks];
  int act_run;
  int write_run;
  int read_run;
  int last_phase;
  int checks;
  int phase_checks;
  int phase_errors;

  function automatic sch_class_t class_of(bank_state_t st);
    case (st)
      b_act_check, b_active:  return cls_act;
      b_write_check, b_write: return cls_write;
      b_read_check, b_read:   return cls_read;
      b_pre_check, b_pre:     return cls_pre;
      default:                return cls_none;
    endcase
  endfunction

  function automatic logic [3:0] issue_code(bank_state_t st);
    case (st)
      b_active: return cmd_active;
      b_read:   return cmd_read;
      b_write:  return cmd_write;
      b_pre:    return cmd_precharge;
      default:  return cmd_nop;
    endcase
  endfunction

  function automatic int next_run(int r);
    return (r == run_wrap) ? 1 : r + 1;
  endfunction

  task automatic check_value(string sig, logic [31:0] expected, logic [31:0] actual);
    checks++;
    phase_checks++;
    if (actual !== expected) begin
      error_count++;
      phase_errors++;
      $display("Error %s %s: expected %h actual %h at %0t",
               test_name[phase], sig, expected, actual, $time);
    end
  endtask

  initial begin
    finished     = 1'b0;
    error_count  = 0;
    checks       = 0;
    phase_checks = 0;
    phase_errors = 0;
    last_phase   = 0;
  end

  //////////////////////////////
  // reference model

  always @(posedge clk) begin : model_update
    logic any_a;
    logic any_w;
    logic any_r;
    any_a = 1'b0;
    any_w = 1'b0;
    any_r = 1'b0;
    if (!rst_n) begin
      for (int i = 0; i < num_banks; i++)
        age[i] = 0;
      act_run   = 0;
      write_run = 0;
      read_run  = 0;
    end else begin
      for (int i = 0; i < num_banks; i++) begin
        any_a |= (ba_state[i] == b_active);
        any_w |= (ba_state[i] == b_write);
        any_r |= (ba_state[i] == b_read);
        if (ba_state[i] == b_idle || ba_state[i] == b_act_standby)
          age[i] = 0;
        else if (age[i] < age_max)
          age[i]++;  // saturates
      end
      if (any_a)
        act_run = next_run(act_run);
      if (any_w)
        write_run = next_run(write_run);
      else if (any_r)
        write_run = 0;
      if (any_r)
        read_run = next_run(read_run);
      else if (any_w)
        read_run = 0;
    end
  end

  //////////////////////////////
  // compare

  always @(negedge clk) begin : compare
    logic                 pend_act;
    logic                 pend_wr;
    logic                 pend_rd;
    logic                 pend_pre;
    logic                 exp_issue;
    logic [num_banks-1:0] exp_stall;
    sch_word_t            exp_out;
    sch_class_t           access;
    sch_class_t           grant;
    int                   oldest;
    int                   pick;
    int                   sel;
    if (phase != last_phase && last_phase >= 1 && last_phase <= 6) begin
      $display("%s: %0d checks, %0d errors, %s", test_name[last_phase], phase_checks,
               phase_errors, (phase_errors == 0) ? "pass" : "fail");
      phase_checks = 0;
      phase_errors = 0;
    end
    if (phase > 6 && !finished) begin
      $display("all tests: %0d checks, %0d errors", checks, error_count);
      finished = 1'b1;
    end
    last_phase = phase;
    if (rst_n && phase >= 1 && phase <= 6) begin
      exp_issue = 1'b0;
      sel       = 0;
      for (int i = num_banks - 1; i >= 0; i--) begin
        if (issue_code(ba_state[i]) != cmd_nop) begin
          exp_issue = 1'b1;
          sel       = i;  // lowest index ends up last
        end
      end
      exp_out  = {issue_code(ba_state[sel]), ba_addr[sel], 1'b0, bank_idx_t'(sel)};
      pend_act = 1'b0;
      pend_wr  = 1'b0;
      pend_rd  = 1'b0;
      pend_pre = 1'b0;
      oldest   = 0;
      for (int i = 0; i < num_banks; i++) begin
        pend_act |= (class_of(ba_state[i]) == cls_act);
        pend_wr  |= (class_of(ba_state[i]) == cls_write);
        pend_rd  |= (class_of(ba_state[i]) == cls_read);
        pend_pre |= (class_of(ba_state[i]) == cls_pre);
        if (age[i] > age[oldest])
          oldest = i;
      end
      access = cls_none;
      if (pend_wr && !pend_rd)
        access = cls_write;
      else if (pend_rd && !pend_wr)
        access = cls_read;
      else if (pend_wr && pend_rd) begin
        if (write_run != 0 && read_run == 0)
          access = cls_write;
        else if (read_run != 0 && write_run == 0)
          access = cls_read;
        else
          access = (class_of(ba_state[oldest]) == cls_write) ? cls_write : cls_read;
      end
      if (pend_pre)
        grant = cls_pre;
      else if (pend_act && (access == cls_none || class_of(ba_state[oldest]) == cls_act ||
                            act_run < act_run_limit))
        grant = cls_act;
      else
        grant = access;
      exp_stall = '1;
      pick      = -1;
      if (grant != cls_none && !isu_fifo_full) begin
        for (int i = 0; i < num_banks; i++)
          if (class_of(ba_state[i]) == grant && (pick < 0 || age[i] > age[pick]))
            pick = i;
        if (pick >= 0)
          exp_stall[pick] = 1'b0;
      end
      check_value("sch_out", 32'(exp_out), 32'(sch_out));
      check_value("sch_issue", 32'(exp_issue), 32'(sch_issue));
      check_value("ba_stall", 32'(exp_stall), 32'(ba_stall));
    end
  end

endmodule

//--- tb/tb_cmd_scheduler.sv
// six random phases of 400 cycles from seed 1671; the run stops at a fixed cycle limit
`timescale 1ns/1ps

module tb_cmd_scheduler;

  import sch_pkg::*;

  localparam int reset_cycles = 8;
  localparam int phase_cycles = 400;
  localparam int num_tests    = 6;
  localparam int cycle_limit  = reset_cycles + num_tests * phase_cycles + 100;

  logic                 clk;
  logic                 rst_n;
  logic                 isu_fifo_full;
  bank_state_t          ba_state [num_banks];
  row_addr_t            ba_addr  [num_banks];
  logic [num_banks-1:0] ba_stall;
  sch_word_t            sch_out;
  logic                 sch_issue;
  int                   phase;
  int                   cycles;
  int                   hold [num_banks];
  int                   span_left;
  sch_class_t           span_cls;
  logic                 finished;
  int                   error_count;

  cmd_scheduler i_cmd_scheduler (
    .clk           (clk),
    .rst_n         (rst_n),
    .isu_fifo_full (isu_fifo_full),
    .ba_state      (ba_state),
    .ba_addr       (ba_addr),
    .ba_stall      (ba_stall),
    .sch_out       (sch_out),
    .sch_issue     (sch_issue)
  );

  sch_checker i_sch_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .phase         (phase),
    .isu_fifo_full (isu_fifo_full),
    .ba_state      (ba_state),
    .ba_addr       (ba_addr),
    .ba_stall      (ba_stall),
    .sch_out       (sch_out),
    .sch_issue     (sch_issue),
    .finished      (finished),
    .error_count   (error_count)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout: run did not complete within %0d cycles", cycle_limit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // stimulus

  // state draw biased toward the phase's behavior
  function automatic bank_state_t pick_state(int ph, sch_class_t cls);
    int r;
    r = $urandom_range(0, 9);
    case (ph)
      2: begin
        if (r < 2)
          return (r == 0) ? b_idle : b_act_standby;
        case (cls)
          cls_act:   return (r < 5) ? b_act_check : b_active;
          cls_write: return (r < 5) ? b_write_check : b_write;
          cls_read:  return (r < 5) ? b_read_check : b_read;
          default:   return (r < 5) ? b_pre_check : b_pre;
        endcase
      end
      4:       return bank_state_t'((r < 2) ? 0 : r % 4 + 4);      // idle, write, read
      5:       return bank_state_t'((r < 3) ? r + 1 : r % 4 + 4);  // act mixed with access
      6:       return (r < 4) ? ((r < 2) ? b_pre_check : b_pre) : bank_state_t'($urandom_range(0, 7));
      default: return bank_state_t'(r);
    endcase
  endfunction

  task automatic drive_inputs(int ph);
    for (int i = 0; i < num_banks; i++) begin
      if (hold[i] <= 0) begin
        ba_state[i] = pick_state(ph, span_cls);
        hold[i]     = (ph == 1) ? 1 : $urandom_range(1, 8);
      end
      hold[i]--;
      ba_addr[i] = row_addr_t'($urandom);
    end
    isu_fifo_full = (ph == 3) && ($urandom_range(0, 2) == 0);
  endtask

  initial begin
    void'($urandom(1671));
    clk           = 1'b0;
    rst_n         = 1'b0;
    isu_fifo_full = 1'b0;
    phase         = 0;
    cycles        = 0;
    span_left     = 0;
    span_cls      = cls_act;
    for (int i = 0; i < num_banks; i++) begin
      ba_state[i] = b_idle;
      ba_addr[i]  = '0;
      hold[i]     = 0;
    end
    repeat (reset_cycles) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int ph = 1; ph <= num_tests; ph++) begin
      phase     = ph;
      span_left = 0;
      for (int n = 0; n < phase_cycles; n++) begin
        if (ph == 2 && span_left <= 0) begin
          span_cls  = sch_class_t'($urandom_range(1, 4));
          span_left = $urandom_range(20, 60);
          for (int i = 0; i < num_banks; i++)
            hold[i] = 0;  // every bank moves into the new class
        end
        span_left--;
        drive_inputs(ph);
        @(posedge clk);
        #2;
      end
    end
    phase = num_tests + 1;
    wait (finished === 1'b1);
    if (error_count == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- files.f
hw/sch_pkg.sv
hw/bank_age_tracker.sv
hw/class_arbiter.sv
hw/oldest_bank_select.sv
hw/cmd_issue_mux.sv
hw/cmd_scheduler.sv
tb/sch_checker.sv
tb/tb_cmd_scheduler.sv

//--- Bender.yml
package:
  name: cmd_scheduler

sources:
  - hw/sch_pkg.sv
  - hw/bank_age_tracker.sv
  - hw/class_arbiter.sv
  - hw/oldest_bank_select.sv
  - hw/cmd_issue_mux.sv
  - hw/cmd_scheduler.sv
  - target: simulation
    files:
      - tb/sch_checker.sv
      - tb/tb_cmd_scheduler.sv
